/* verilog/mxv_pkg.sv */
package mxv_pkg;

	localparam int MAX_DIM   = 8;     // largest n from a SIZE frame
	localparam int MAX_FRAME = 64;    // largest frame size field
	localparam int ELEM_MAX  = 255;   // largest operand element
	localparam int VAL_MAX   = 511;   // number fields saturate here
	localparam int MAT_DEPTH = 64;
	localparam int VEC_DEPTH = 8;
	localparam int ADDR_W    = 6;

	localparam logic [7:0] CH_UNDERSCORE = 8'h5f;
	localparam logic [7:0] CH_ZERO       = 8'h30;
	localparam logic [7:0] CH_NINE       = 8'h39;
	localparam logic [7:0] CH_F          = 8'h46;
	localparam logic [7:0] CH_E          = 8'h45;

	typedef enum logic [1:0] {
		FIELD_NUM,
		FIELD_FE,
		FIELD_EF,
		FIELD_BAD
	} field_kind_t;

	typedef logic [8:0] field_val_t;   // decimal value of a number field

	typedef enum logic [2:0] {
		CMD_NONE   = 3'd0,
		CMD_START  = 3'd1,
		CMD_REPEAT = 3'd2,
		CMD_SIZE   = 3'd3,
		CMD_MV     = 3'd4
	} command_t;

	typedef logic [3:0] dim_t;
	typedef logic [7:0] elem_t;

endpackage

/* verilog/store_wr_if.sv */
`timescale 1ns/1ps

interface store_wr_if;

	logic                       wr;       // write data at addr
	logic [mxv_pkg::ADDR_W-1:0] addr;
	mxv_pkg::elem_t             data;
	logic                       clear;    // drop loaded flag
	logic                       commit;   // raise loaded flag

	modport parser (
		output wr,
		output addr,
		output data,
		output clear,
		output commit
	);

	modport store (
		input wr,
		input addr,
		input data,
		input clear,
		input commit
	);

endinterface

/* verilog/field_assembler.sv */
`timescale 1ns/1ps

module field_assembler (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 rcv,
	input  logic [7:0]           ch,
	output logic                 field_valid,
	output mxv_pkg::field_kind_t field_kind,
	output mxv_pkg::field_val_t  field_value
);

	typedef enum logic [2:0] {LS_NONE, LS_F, LS_E, LS_FE, LS_EF} let_st_t;

	mxv_pkg::field_val_t  acc;
	logic [12:0]          acc_next;    // 511*10+9 fits
	logic [3:0]           digit;
	let_st_t              let_st;
	logic                 has_digit;
	logic                 bad;
	logic                 is_digit;
	logic                 is_end;
	mxv_pkg::field_kind_t kind_now;

	assign is_end   = (ch == mxv_pkg::CH_UNDERSCORE);
	assign is_digit = (ch >= mxv_pkg::CH_ZERO) && (ch <= mxv_pkg::CH_NINE);
	assign digit    = ch[3:0];    // ascii digits keep their value in the low nibble
	assign acc_next = acc * 13'd10 + 13'(digit);

	always_comb begin
		if (bad || (has_digit && let_st != LS_NONE)) begin
			kind_now = mxv_pkg::FIELD_BAD;    // mixed or stray character
		end else if (has_digit) begin
			kind_now = mxv_pkg::FIELD_NUM;
		end else if (let_st == LS_FE) begin
			kind_now = mxv_pkg::FIELD_FE;
		end else if (let_st == LS_EF) begin
			kind_now = mxv_pkg::FIELD_EF;
		end else begin
			kind_now = mxv_pkg::FIELD_BAD;    // empty or lone letter
		end
	end

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			field_valid <= 1'b0;
			acc         <= '0;
			let_st      <= LS_NONE;
			has_digit   <= 1'b0;
			bad         <= 1'b0;
		end else begin
			field_valid <= rcv && is_end;
			if (rcv) begin
				if (is_end) begin
					acc       <= '0;    // start next field
					let_st    <= LS_NONE;
					has_digit <= 1'b0;
					bad       <= 1'b0;
				end else if (is_digit) begin
					has_digit <= 1'b1;
					if (acc_next > mxv_pkg::VAL_MAX) begin
						acc <= mxv_pkg::field_val_t'(mxv_pkg::VAL_MAX);
					end else begin
						acc <= acc_next[8:0];
					end
				end else if (ch == mxv_pkg::CH_F) begin
					case (let_st)
						LS_NONE: let_st <= LS_F;
						LS_E:    let_st <= LS_EF;
						default: bad    <= 1'b1;
					endcase
				end else if (ch == mxv_pkg::CH_E) begin
					case (let_st)
						LS_NONE: let_st <= LS_E;
						LS_F:    let_st <= LS_FE;
						default: bad    <= 1'b1;
					endcase
				end else begin
					bad <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rcv && is_end) begin
			field_kind  <= kind_now;
			field_value <= acc;
		end
	end

	// a legal field needs at least one character, so only a bad field can follow back to back
	a_field_gap: assert property (@(posedge clk) disable iff (!rst)
		field_valid |=> !field_valid || field_kind == mxv_pkg::FIELD_BAD);

endmodule

/* verilog/frame_parser.sv */
`timescale 1ns/1ps

module frame_parser (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 field_valid,
	input  mxv_pkg::field_kind_t field_kind,
	input  mxv_pkg::field_val_t  field_value,
	output logic                 frame_ok,
	output logic                 frame_err,
	output mxv_pkg::command_t    cmd,
	output mxv_pkg::dim_t        n,
	store_wr_if.parser           mat_wr,
	store_wr_if.parser           vec_wr
);

	typedef enum logic [2:0] {HUNT, SIZE, CMD, DIM, PAYLOAD, END} state_t;

	state_t                     state;
	state_t                     nxt;
	logic                       accept;
	logic                       is_num;
	logic [mxv_pkg::ADDR_W:0]   fsize;    // up to 64
	logic [mxv_pkg::ADDR_W:0]   cnt;
	logic [mxv_pkg::ADDR_W:0]   n_sq;
	mxv_pkg::command_t          cmd_code;
	mxv_pkg::command_t          pend_cmd;
	mxv_pkg::dim_t              new_n;
	logic                       is_mat;
	logic                       wr_mat;
	logic                       wr_vec;
	logic                       clr_mat;
	logic                       clr_vec;
	logic                       cmt_mat;
	logic                       cmt_vec;
	logic [mxv_pkg::ADDR_W-1:0] wr_addr;
	mxv_pkg::elem_t             wr_data;

	assign is_num   = (field_kind == mxv_pkg::FIELD_NUM);
	assign n_sq     = n * n;
	assign cmd_code = mxv_pkg::command_t'(field_value[2:0]);

	always_comb begin
		accept = 1'b0;
		nxt    = HUNT;
		case (state)
			HUNT: begin
				accept = (field_kind == mxv_pkg::FIELD_FE);
				nxt    = SIZE;
			end
			SIZE: begin
				accept = is_num && field_value != 0 && field_value <= mxv_pkg::MAX_FRAME;
				nxt    = CMD;
			end
			CMD: begin
				nxt = END;
				if (is_num && field_value != 0 && field_value <= mxv_pkg::CMD_MV) begin
					case (cmd_code)
						mxv_pkg::CMD_SIZE: begin
							accept = 1'b1;
							nxt    = DIM;
						end
						mxv_pkg::CMD_MV: begin
							accept = (n != 0) && (fsize == n_sq || fsize == 7'(n));
							nxt    = PAYLOAD;
						end
						default: accept = 1'b1;    // start and repeat carry nothing
					endcase
				end
			end
			DIM: begin
				accept = is_num && field_value != 0 && field_value <= mxv_pkg::MAX_DIM;
				nxt    = END;
			end
			PAYLOAD: begin
				accept = is_num && field_value <= mxv_pkg::ELEM_MAX;
				nxt    = (cnt + 1'b1 == fsize) ? END : PAYLOAD;
			end
			END: begin
				accept = (field_kind == mxv_pkg::FIELD_EF);
				nxt    = HUNT;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			state     <= HUNT;
			frame_ok  <= 1'b0;
			frame_err <= 1'b0;
			cmd       <= mxv_pkg::CMD_NONE;
			n         <= '0;
			cnt       <= '0;
			is_mat    <= 1'b0;
			wr_mat    <= 1'b0;
			wr_vec    <= 1'b0;
			clr_mat   <= 1'b0;
			clr_vec   <= 1'b0;
			cmt_mat   <= 1'b0;
			cmt_vec   <= 1'b0;
		end else begin
			frame_ok  <= 1'b0;
			frame_err <= 1'b0;
			wr_mat    <= 1'b0;
			wr_vec    <= 1'b0;
			clr_mat   <= 1'b0;
			clr_vec   <= 1'b0;
			cmt_mat   <= 1'b0;
			cmt_vec   <= 1'b0;
			if (field_valid && accept) begin
				state <= nxt;
				case (state)
					CMD: begin
						if (cmd_code == mxv_pkg::CMD_MV) begin
							is_mat  <= (fsize == n_sq);    // n of 1 counts as matrix
							clr_mat <= (fsize == n_sq);
							clr_vec <= (fsize != n_sq);
							cnt     <= '0;
						end
					end
					PAYLOAD: begin
						wr_mat <= is_mat;
						wr_vec <= !is_mat;
						cnt    <= cnt + 1'b1;
					end
					END: begin
						frame_ok <= 1'b1;
						cmd      <= pend_cmd;
						if (pend_cmd == mxv_pkg::CMD_SIZE) begin
							n       <= new_n;
							clr_mat <= 1'b1;
							clr_vec <= 1'b1;
						end
						if (pend_cmd == mxv_pkg::CMD_MV) begin
							cmt_mat <= is_mat;
							cmt_vec <= !is_mat;
						end
					end
					default: ;
				endcase
			end else if (field_valid && state != HUNT) begin
				frame_err <= 1'b1;
				// an FE inside a frame opens the next one
				state <= (field_kind == mxv_pkg::FIELD_FE) ? SIZE : HUNT;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (field_valid) begin
			case (state)
				SIZE:    fsize <= field_value[mxv_pkg::ADDR_W:0];
				CMD:     pend_cmd <= cmd_code;
				DIM:     new_n <= field_value[3:0];
				PAYLOAD: begin
					wr_addr <= cnt[mxv_pkg::ADDR_W-1:0];    // row-major element index
					wr_data <= field_value[7:0];
				end
				default: ;
			endcase
		end
	end

	assign mat_wr.wr     = wr_mat;
	assign mat_wr.addr   = wr_addr;
	assign mat_wr.data   = wr_data;
	assign mat_wr.clear  = clr_mat;
	assign mat_wr.commit = cmt_mat;
	assign vec_wr.wr     = wr_vec;
	assign vec_wr.addr   = wr_addr;
	assign vec_wr.data   = wr_data;
	assign vec_wr.clear  = clr_vec;
	assign vec_wr.commit = cmt_vec;

	a_ok_err: assert property (@(posedge clk) disable iff (!rst)
		!(frame_ok && frame_err));

	// a write lands inside the payload that the frame size announced
	a_wr_payload: assert property (@(posedge clk) disable iff (!rst)
		(wr_mat || wr_vec) |-> wr_addr < fsize);

endmodule

/* verilog/operand_store.sv */
`timescale 1ns/1ps

module operand_store #(
	parameter int DEPTH = mxv_pkg::MAT_DEPTH
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [mxv_pkg::ADDR_W-1:0] rd_addr,
	output mxv_pkg::elem_t             rd_data,
	output logic                       loaded,
	store_wr_if.store                  wr
);

	mxv_pkg::elem_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr.wr) begin
			mem[wr.addr[$clog2(DEPTH)-1:0]] <= wr.data;
		end
		rd_data <= mem[rd_addr[$clog2(DEPTH)-1:0]];    // registered read
	end

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			loaded <= 1'b0;
		end else if (wr.clear) begin
			loaded <= 1'b0;
		end else if (wr.commit) begin
			loaded <= 1'b1;    // frame closed with EF
		end
	end

	// parser address must fit this store's depth
	a_wr_addr: assert property (@(posedge clk) disable iff (!rst)
		wr.wr |-> wr.addr < DEPTH);

endmodule

/* verilog/mxv_frame_rx.sv */
`timescale 1ns/1ps

module mxv_frame_rx (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       rcv,
	input  logic [7:0]                 ch,
	input  logic [mxv_pkg::ADDR_W-1:0] m_rd_addr,
	input  logic [mxv_pkg::ADDR_W-1:0] v_rd_addr,
	output logic                       frame_ok,
	output logic                       frame_err,
	output mxv_pkg::command_t          cmd,
	output mxv_pkg::dim_t              n,
	output logic                       m_loaded,
	output logic                       v_loaded,
	output mxv_pkg::elem_t             m_rd_data,
	output mxv_pkg::elem_t             v_rd_data
);

	logic                 field_valid;
	mxv_pkg::field_kind_t field_kind;
	mxv_pkg::field_val_t  field_value;

	store_wr_if mat_wr ();
	store_wr_if vec_wr ();

	field_assembler u_asm (
		.clk         (clk),
		.rst         (rst),
		.rcv         (rcv),
		.ch          (ch),
		.field_valid (field_valid),
		.field_kind  (field_kind),
		.field_value (field_value)
	);

	frame_parser u_parser (
		.clk         (clk),
		.rst         (rst),
		.field_valid (field_valid),
		.field_kind  (field_kind),
		.field_value (field_value),
		.frame_ok    (frame_ok),
		.frame_err   (frame_err),
		.cmd         (cmd),
		.n           (n),
		.mat_wr      (mat_wr.parser),
		.vec_wr      (vec_wr.parser)
	);

	operand_store #(.DEPTH(mxv_pkg::MAT_DEPTH)) u_mat_store (
		.clk     (clk),
		.rst     (rst),
		.rd_addr (m_rd_addr),
		.rd_data (m_rd_data),
		.loaded  (m_loaded),
		.wr      (mat_wr.store)
	);

	operand_store #(.DEPTH(mxv_pkg::VEC_DEPTH)) u_vec_store (
		.clk     (clk),
		.rst     (rst),
		.rd_addr (v_rd_addr),
		.rd_data (v_rd_data),
		.loaded  (v_loaded),
		.wr      (vec_wr.store)
	);

endmodule

/* test/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;    // 8 ns period
		end
	end

	initial begin
		rst = 1'b0;    // active low for 8 cycles
		repeat (8) @(posedge clk);
		#1 rst = 1'b1;
	end

endmodule

/* test/tb_mxv_frame_rx.sv */
`timescale 1ns/1ps

module tb_mxv_frame_rx;

	logic                       clk;
	logic                       rst;
	logic                       rcv;
	logic [7:0]                 ch;
	logic [mxv_pkg::ADDR_W-1:0] m_rd_addr;
	logic [mxv_pkg::ADDR_W-1:0] v_rd_addr;
	logic                       frame_ok;
	logic                       frame_err;
	mxv_pkg::command_t          cmd;
	mxv_pkg::dim_t              n;
	logic                       m_loaded;
	logic                       v_loaded;
	mxv_pkg::elem_t             m_rd_data;
	mxv_pkg::elem_t             v_rd_data;

	mxv_pkg::command_t got_cmd;    // latched at frame_ok
	mxv_pkg::dim_t     got_n;
	int                ok_cnt = 0;
	int                err_cnt = 0;
	int                ok_exp = 0;
	int                err_exp = 0;
	int                errors = 0;
	int                errors_base = 0;
	int                n_tests = 0;
	int                n_failed = 0;
	int                wd_cycles = 0;
	string             test_name = "";

	clock_gen u_clk (.*);

	mxv_frame_rx uut (.*);

	always @(negedge clk) begin
		if (frame_ok) begin
			ok_cnt++;
			got_cmd = cmd;
			got_n   = n;
		end
		if (frame_err) begin
			err_cnt++;
		end
	end

	// one character per strobe, then 0 to 3 idle cycles
	task automatic send_stream(input string s);
		int i;
		int idle;
		for (i = 0; i < s.len(); i++) begin
			rcv  = 1'b1;
			ch   = s[i];
			idle = $urandom % 4;
			repeat (idle + 1) begin
				@(posedge clk);
				#1;
				rcv = 1'b0;
			end
		end
		repeat (4) begin    // let the frame drain through all stages
			@(posedge clk);
			#1;
		end
	endtask

	task automatic finish_test();
		assert (ok_cnt == ok_exp && err_cnt == err_exp) else begin
			$display("Fail %0t: %0d frame_ok and %0d frame_err pulses, expected %0d and %0d",
				$time, ok_cnt, err_cnt, ok_exp, err_exp);
			errors++;
		end
		n_tests++;
		if (errors == errors_base) begin
			$display("test %s: ok", test_name);
		end else begin
			n_failed++;
			$display("test %s: %0d failed checks", test_name, errors - errors_base);
		end
	endtask

	initial begin
		int                fd;
		int                nchars;
		int                nv;
		int                k;
		int                addr;
		int                v[10];
		string             line;
		string             arg;
		string             lines[$];
		mxv_pkg::command_t exp_cmd;
		mxv_pkg::elem_t    rd;
		void'($urandom(32'h4b68_8e97));
		rcv       = 1'b0;
		ch        = 8'h00;
		m_rd_addr = '0;
		v_rd_addr = '0;
		nchars    = 0;
		fd = $fopen("test/mxv_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open test/mxv_vectors.txt");
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				while (line.len() > 0 && line[line.len()-1] <= 8'h20) begin
					line = line.substr(0, line.len() - 2);    // strip line end
				end
				if (line.len() > 0 && line[0] != "#") begin
					lines.push_back(line);
					if (line[0] == "S") begin
						nchars += line.len() - 2;
					end
				end
			end
			$fclose(fd);
		end
		wd_cycles = 200 + 8 * nchars;
		wait (rst === 1'b1);
		@(posedge clk);
		#1;
		foreach (lines[i]) begin
			line = lines[i];
			arg  = line.substr(2, line.len() - 1);
			nv   = $sscanf(arg, "%d %d %d %d %d %d %d %d %d %d", v[0], v[1], v[2], v[3],
				v[4], v[5], v[6], v[7], v[8], v[9]);
			case (line[0])
				"T": begin
					if (test_name != "") begin
						finish_test();
					end
					test_name   = arg;
					ok_exp      = ok_cnt;
					err_exp     = err_cnt;
					errors_base = errors;
				end
				"S": send_stream(arg);
				"O": begin
					ok_exp++;
					exp_cmd = mxv_pkg::command_t'(v[0]);
					assert (got_cmd == exp_cmd && int'(got_n) == v[1]) else begin
						$display("Fail %0t: got %s n %0d, expected %s n %0d", $time,
							got_cmd.name(), got_n, exp_cmd.name(), v[1]);
						errors++;
					end
				end
				"E": err_exp++;
				"L": begin
					assert (int'(m_loaded) == v[0] && int'(v_loaded) == v[1]) else begin
						$display("Fail %0t: loaded m %0b v %0b, expected m %0d v %0d", $time,
							m_loaded, v_loaded, v[0], v[1]);
						errors++;
					end
				end
				"M", "V": begin
					for (k = 1; k < nv; k++) begin
						addr      = v[0] + k - 1;
						m_rd_addr = addr[mxv_pkg::ADDR_W-1:0];
						v_rd_addr = addr[mxv_pkg::ADDR_W-1:0];
						@(posedge clk);
						#1;    // registered read is out now
						rd = (line[0] == "M") ? m_rd_data : v_rd_data;
						assert (int'(rd) == v[k]) else begin
							$display("Fail %0t: %s[%0d] = %0d, expected %0d", $time,
								line.substr(0, 0), addr, rd, v[k]);
							errors++;
						end
					end
				end
				default: begin
					$display("unknown vector line: %s", line);
					errors++;
				end
			endcase
		end
		if (test_name != "") begin
			finish_test();
		end
		$display("%0d tests, %0d failed, %0d failed checks", n_tests, n_failed, errors);
		if (errors == 0 && n_tests > 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// limit follows the number of characters in the vector file
	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
		$display("Test failures found");
		$finish;
	end

endmodule

/* compile.f */
verilog/mxv_pkg.sv
verilog/store_wr_if.sv
verilog/field_assembler.sv
verilog/frame_parser.sv
verilog/operand_store.sv
verilog/mxv_frame_rx.sv
test/clock_gen.sv
test/tb_mxv_frame_rx.sv

/* Makefile */
TOP = tb_mxv_frame_rx

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "All tests passed!" > /dev/null

clean:
	rm -rf obj_dir

/* test/mxv_vectors.txt */
# T name starts a test; S characters to send; O cmd and n at the last frame_ok; E one frame_err
# L m_loaded v_loaded; M or V first address, then the elements read back from there on
T size_frame
S FE_1_3_3_EF_
O 3 3
L 0 0
T matrix_load
S FE_9_4_10_20_30_40_50_60_70_80_255_EF_
O 4 3
L 1 0
M 0 10 20 30 40 50 60 70 80 255
T vector_load
S FE_3_4_5_6_7_EF_
O 4 3
L 1 1
V 0 5 6 7
S FE_1_1_EF_
O 1 3
L 1 1
T size_mismatch
S FE_5_4_1_2_3_4_5_EF_FE_1_2_EF_
E
O 2 3
L 1 1
T bad_element
S FE_9_4_1_2_300_4_5_6_7_8_9_EF_
E
L 0 1
T stray_letter
S FE_3_4_1_2F_3_EF_
E
L 0 0
T empty_field
S FE_9_4_1__2_3_4_5_6_7_8_EF_
E
L 0 0
T missing_ef
S FE_3_4_1_2_3_FE_1_1_EF_
E
O 1 3
L 0 0
T new_size
S FE_3_4_9_8_7_EF_
O 4 3
L 0 1
S FE_1_3_5_EF_
O 3 5
L 0 0
